/* raycast_pkg.sv */
package raycast_pkg;

   // screen geometry after the 4x downscale
   localparam logic [15:0] screen_width = 16'd320;       // columns, also the row stride
   localparam logic [7:0]  screen_height = 8'd180;       // rows per column
   localparam logic [7:0]  half_screen_height = 8'd90;   // horizon row

   localparam int          fb_addr_bits = 16;
   localparam logic [15:0] fb_depth = 16'd57600;         // 320 * 180 pixels
   localparam int          pixel_bits = 16;              // rgb565
   localparam int          vcount_bits = 8;

   // column record layout, msb first
   localparam int record_bits = 23;
   localparam int hcount_bits = 9;
   localparam int line_height_bits = 8;
   localparam int map_data_bits = 4;
   localparam int hcount_lsb = 14;                       // [22:14]
   localparam int line_height_lsb = 6;                   // [13:6]
   localparam int wall_type_bit = 5;                     // 0 = x side, 1 = y side
   localparam int map_data_lsb = 1;                      // [4:1]
   localparam int last_bit = 0;                          // last column of the frame

   localparam logic [3:0] fifo_depth = 4'd8;
   localparam int         fifo_ptr_bits = 3;
   localparam int         fifo_count_bits = 4;           // holds 0..8

   localparam logic [15:0] background_color = 16'hFFFF;  // ceiling and floor

   // entry 0 matches the background so an empty cell draws nothing
   localparam logic [15:0] wall_palette [0:15] = '{
      16'hFFFF, 16'hF800, 16'h07E0, 16'h001F,
      16'hFFE0, 16'h07FF, 16'hF81F, 16'h8410,
      16'hFD20, 16'h8000, 16'h0400, 16'h0010,
      16'h8400, 16'h4208, 16'hA145, 16'h0000
   };

   // y side hits are drawn at half brightness, each channel halved on its own
   function automatic logic [pixel_bits-1:0] shade_pixel(
      input logic [map_data_bits-1:0] map_data,
      input logic                     wall_type
   );
      logic [pixel_bits-1:0] base;
      base = wall_palette[map_data];
      if (wall_type) begin
         return {1'b0, base[15:12], 1'b0, base[10:6], 1'b0, base[4:1]}; // r, g, b
      end
      return base;
   endfunction

endpackage

/* ray_column_fifo.sv */
`timescale 1ns/1ns

module ray_column_fifo (
   input  logic                                pixel_clk_in,
   input  logic                                rst_in,
   input  logic                                column_we,    // producer write strobe
   input  logic [raycast_pkg::record_bits-1:0] column_data,
   input  logic                                fifo_pop,     // flattener takes the head
   output logic                                column_full,
   output logic                                fifo_empty,
   output logic [raycast_pkg::record_bits-1:0] fifo_data     // head record, no read delay
);

   // record storage
   logic [raycast_pkg::record_bits-1:0] mem [0:raycast_pkg::fifo_depth-1];

   logic [raycast_pkg::fifo_ptr_bits-1:0]   wr_ptr;
   logic [raycast_pkg::fifo_ptr_bits-1:0]   rd_ptr;
   logic [raycast_pkg::fifo_count_bits-1:0] count;

   logic push; // accepted write
   logic pop;  // accepted read

   // levels straight off the count
   assign column_full = (count == raycast_pkg::fifo_depth);
   assign fifo_empty  = (count == '0);

   // writes while full are dropped here, the producer is expected to watch column_full
   assign push = column_we && !column_full;
   assign pop  = fifo_pop && !fifo_empty;

   assign fifo_data = mem[rd_ptr]; // first-word fall-through

   always_ff @(posedge pixel_clk_in) begin
      if (push) begin
         mem[wr_ptr] <= column_data;
      end
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge pixel_clk_in) begin
      if (rst_in) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 3'd1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 3'd1;
         end
         case ({push, pop})
            2'b10:   count <= count + 4'd1; // write only
            2'b01:   count <= count - 4'd1; // read only
            default: count <= count;        // both or neither
         endcase
      end
   end

endmodule

/* column_flattener.sv */
`timescale 1ns/1ns

module column_flattener (
   input  logic                                 pixel_clk_in,
   input  logic                                 rst_in,
   input  logic                                 fifo_empty,
   input  logic [raycast_pkg::record_bits-1:0]  fifo_data,
   output logic                                 fifo_pop,
   output logic                                 pixel_we,
   output logic [raycast_pkg::fb_addr_bits-1:0] pixel_addr,
   output logic [raycast_pkg::pixel_bits-1:0]   pixel_data,
   output logic                                 frame_done
);

   // head record fields
   logic [raycast_pkg::hcount_bits-1:0]      rec_hcount;
   logic [raycast_pkg::line_height_bits-1:0] rec_line_height;
   logic                                     rec_wall_type;
   logic [raycast_pkg::map_data_bits-1:0]    rec_map_data;
   logic                                     rec_last;

   // draw bounds for the head record
   logic [raycast_pkg::line_height_bits-1:0] half_height;
   logic                                     clamp_bounds;
   logic [raycast_pkg::vcount_bits-1:0]      start_d;
   logic [raycast_pkg::vcount_bits-1:0]      end_d;

   // control state
   logic                                     sweeping;   // 0 waits for a record, 1 sweeps rows
   logic [raycast_pkg::vcount_bits-1:0]      vcount;
   logic                                     last_row;

   // latched column
   logic [raycast_pkg::map_data_bits-1:0]    col_map_data;
   logic                                     col_wall_type;
   logic                                     col_last;
   logic [raycast_pkg::vcount_bits-1:0]      draw_start;
   logic [raycast_pkg::vcount_bits-1:0]      draw_end;
   logic [raycast_pkg::fb_addr_bits-1:0]     row_addr;   // running row * 320 + hcount
   logic                                     in_wall;

   assign rec_hcount      = fifo_data[raycast_pkg::hcount_lsb +: raycast_pkg::hcount_bits];
   assign rec_line_height = fifo_data[raycast_pkg::line_height_lsb +: raycast_pkg::line_height_bits];
   assign rec_wall_type   = fifo_data[raycast_pkg::wall_type_bit];
   assign rec_map_data    = fifo_data[raycast_pkg::map_data_lsb +: raycast_pkg::map_data_bits];
   assign rec_last        = fifo_data[raycast_pkg::last_bit];

   // wall spans half the line height either side of the horizon
   assign half_height  = rec_line_height >> 1;
   assign clamp_bounds = (half_height >= raycast_pkg::half_screen_height); // both ends clip together
   assign start_d = clamp_bounds ? '0 : raycast_pkg::half_screen_height - half_height;
   assign end_d   = clamp_bounds ? raycast_pkg::screen_height
                                 : raycast_pkg::half_screen_height + half_height;

   assign fifo_pop = !sweeping && !fifo_empty; // take the head as soon as we are idle
   assign last_row = (vcount == raycast_pkg::screen_height - 8'd1);

   // pixel outputs come straight from the sweep registers
   assign in_wall    = (vcount >= draw_start) && (vcount < draw_end);
   assign pixel_we   = sweeping;
   assign pixel_addr = row_addr;
   assign pixel_data = in_wall ? raycast_pkg::shade_pixel(col_map_data, col_wall_type)
                               : raycast_pkg::background_color;

   always_ff @(posedge pixel_clk_in) begin
      if (rst_in) begin
         sweeping   <= 1'b0;
         vcount     <= '0;
         frame_done <= 1'b0;
      end else begin
         frame_done <= 1'b0; // single cycle pulse
         if (!sweeping) begin
            if (fifo_pop) begin
               sweeping <= 1'b1;
               vcount   <= '0;
            end
         end else if (last_row) begin
            sweeping   <= 1'b0;
            vcount     <= '0;
            frame_done <= col_last; // row 179 of the last column written this cycle
         end else begin
            vcount <= vcount + 8'd1;
         end
      end
   end

   // column payload, only meaningful while sweeping
   always_ff @(posedge pixel_clk_in) begin
      if (fifo_pop) begin
         col_map_data  <= rec_map_data;
         col_wall_type <= rec_wall_type;
         col_last      <= rec_last;
         draw_start    <= start_d;
         draw_end      <= end_d;
         row_addr      <= {{(raycast_pkg::fb_addr_bits - raycast_pkg::hcount_bits){1'b0}},
                           rec_hcount}; // row 0 address
      end else if (sweeping) begin
         row_addr <= row_addr + raycast_pkg::screen_width; // next row down
      end
   end

endmodule

/* frame_buffer.sv */
`timescale 1ns/1ns

module frame_buffer (
   input  logic                                 pixel_clk_in,
   input  logic                                 pixel_we,      // write strobe from the flattener
   input  logic [raycast_pkg::fb_addr_bits-1:0] pixel_addr,    // row * 320 + column
   input  logic [raycast_pkg::pixel_bits-1:0]   pixel_data,    // rgb565
   input  logic [raycast_pkg::fb_addr_bits-1:0] rd_addr,       // display side read address
   output logic [raycast_pkg::pixel_bits-1:0]   rd_pixel       // word at rd_addr, one clock later
);

   // one word per screen pixel, row major
   logic [raycast_pkg::pixel_bits-1:0] mem [0:raycast_pkg::fb_depth-1];

   logic wr_in_range; // write address inside the screen
   logic rd_in_range; // read address inside the screen

   // the 16 bit address space is larger than the screen
   assign wr_in_range = (pixel_addr < raycast_pkg::fb_depth);
   assign rd_in_range = (rd_addr < raycast_pkg::fb_depth);

   // write port
   always_ff @(posedge pixel_clk_in) begin
      if (pixel_we && wr_in_range) begin
         mem[pixel_addr] <= pixel_data;
      end
   end

   // registered read port
   // a same-address write in this cycle lands after the read, so the old word comes back
   always_ff @(posedge pixel_clk_in) begin
      if (rd_in_range) begin
         rd_pixel <= mem[rd_addr];
      end else begin
         rd_pixel <= raycast_pkg::background_color; // off screen reads as background
      end
   end

endmodule

/* raycast_backend.sv */
`timescale 1ns/1ns

module raycast_backend (
   input  logic                                 pixel_clk_in,
   input  logic                                 rst_in,
   input  logic                                 column_we,    // one record per strobe
   input  logic [raycast_pkg::record_bits-1:0]  column_data,
   input  logic [raycast_pkg::fb_addr_bits-1:0] rd_addr,
   output logic                                 column_full,  // producer must hold off
   output logic [raycast_pkg::pixel_bits-1:0]   rd_pixel,
   output logic                                 frame_done    // last pixel of the frame written
);

   // fifo to flattener
   logic                                 fifo_empty;
   logic [raycast_pkg::record_bits-1:0]  fifo_data;
   logic                                 fifo_pop;

   // flattener to frame buffer
   logic                                 pixel_we;
   logic [raycast_pkg::fb_addr_bits-1:0] pixel_addr;
   logic [raycast_pkg::pixel_bits-1:0]   pixel_data;

   ray_column_fifo u_fifo (
      .pixel_clk_in (pixel_clk_in),
      .rst_in       (rst_in),
      .column_we    (column_we),
      .column_data  (column_data),
      .fifo_pop     (fifo_pop),
      .column_full  (column_full),
      .fifo_empty   (fifo_empty),
      .fifo_data    (fifo_data)
   );

   column_flattener u_flattener (
      .pixel_clk_in (pixel_clk_in),
      .rst_in       (rst_in),
      .fifo_empty   (fifo_empty),
      .fifo_data    (fifo_data),
      .fifo_pop     (fifo_pop),
      .pixel_we     (pixel_we),
      .pixel_addr   (pixel_addr),
      .pixel_data   (pixel_data),
      .frame_done   (frame_done)
   );

   frame_buffer u_frame_buffer (
      .pixel_clk_in (pixel_clk_in),
      .pixel_we     (pixel_we),
      .pixel_addr   (pixel_addr),
      .pixel_data   (pixel_data),
      .rd_addr      (rd_addr),
      .rd_pixel     (rd_pixel)
   );

endmodule

/* raycast_backend_checker.sv */
`timescale 1ns/1ns

module raycast_backend_checker (
   input logic                                 pixel_clk_in,
   input logic                                 rst_in,
   input logic                                 column_we,
   input logic                                 column_full,
   input logic                                 fifo_empty,
   input logic                                 fifo_pop,
   input logic                                 pixel_we,
   input logic [raycast_pkg::fb_addr_bits-1:0] pixel_addr,
   input logic                                 frame_done
);

   logic [raycast_pkg::fifo_count_bits-1:0] occupancy; // records held, tracked from the strobes

   always_ff @(posedge pixel_clk_in) begin
      if (rst_in) begin
         occupancy <= '0;
      end else begin
         case ({column_we && !column_full, fifo_pop && !fifo_empty})
            2'b10:   occupancy <= occupancy + 4'd1;
            2'b01:   occupancy <= occupancy - 4'd1;
            default: occupancy <= occupancy;
         endcase
      end
   end

   // producer must hold off while full
   a_no_write_when_full: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
      column_we |-> !column_full) else $error("column_we while column_full");

   a_full_at_depth: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
      column_full == (occupancy == raycast_pkg::fifo_depth)) else $error("full level off");

   a_done_one_cycle: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
      frame_done |=> !frame_done) else $error("frame_done longer than one cycle");

   a_write_on_screen: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
      pixel_we |-> (pixel_addr < raycast_pkg::fb_depth)) else $error("pixel write off screen");

   // nothing is written straight out of reset
   a_quiet_after_reset: assert property (@(posedge pixel_clk_in)
      $past(rst_in) |-> !pixel_we) else $error("pixel_we right after reset");

endmodule

bind raycast_backend raycast_backend_checker u_checker (
   .pixel_clk_in (pixel_clk_in),
   .rst_in       (rst_in),
   .column_we    (column_we),
   .column_full  (column_full),
   .fifo_empty   (fifo_empty),
   .fifo_pop     (fifo_pop),
   .pixel_we     (pixel_we),
   .pixel_addr   (pixel_addr),
   .frame_done   (frame_done)
);

/* tb_raycast_backend.sv */
`timescale 1ns/1ns

module tb_raycast_backend;

   localparam int num_cols   = 11;
   localparam int num_random = 4;
   localparam int wait_limit = 4000;   // cycles allowed for any single wait

   logic                                 pixel_clk_in;
   logic                                 rst_in;
   logic                                 column_we;
   logic [raycast_pkg::record_bits-1:0]  column_data;
   logic [raycast_pkg::fb_addr_bits-1:0] rd_addr;
   logic                                 column_full;
   logic [raycast_pkg::pixel_bits-1:0]   rd_pixel;
   logic                                 frame_done;

   // one column per table row with hcount, line height, wall side, map value and last flag
   localparam logic [8:0] tab_hcount [num_cols] = '{
      9'd0, 9'd1, 9'd2, 9'd17, 9'd100, 9'd101, 9'd150, 9'd200, 9'd250, 9'd318, 9'd319};
   localparam logic [7:0] tab_height [num_cols] = '{
      8'd0, 8'd1, 8'd2, 8'd90, 8'd180, 8'd255, 8'd120, 8'd200, 8'd60, 8'd45, 8'd181};
   localparam logic tab_wall [num_cols] = '{
      1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
   localparam logic [3:0] tab_map [num_cols] = '{
      4'd1, 4'd1, 4'd1, 4'd15, 4'd2, 4'd3, 4'd0, 4'd15, 4'd7, 4'd9, 4'd14};
   localparam logic tab_last [num_cols] = '{
      1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

   // random columns of the second frame
   logic [8:0] rnd_hcount [num_random];
   logic [7:0] rnd_height [num_random];
   logic       rnd_wall   [num_random];
   logic [3:0] rnd_map    [num_random];

   integer seed = 32'h6b34cb16;
   int     cycle = 0;              // falling edges seen
   int     done_count = 0;         // frame_done pulses after reset
   int     done_cycle = 0;
   int     first_write_cycle = 0;
   logic   full_seen = 1'b0;

   raycast_backend u_raycast_backend (
      .pixel_clk_in (pixel_clk_in),
      .rst_in       (rst_in),
      .column_we    (column_we),
      .column_data  (column_data),
      .rd_addr      (rd_addr),
      .column_full  (column_full),
      .rd_pixel     (rd_pixel),
      .frame_done   (frame_done)
   );

   always #10 pixel_clk_in = ~pixel_clk_in; // 20 ns period

   // pulse and level monitor on the falling edge where outputs are stable
   always @(negedge pixel_clk_in) begin
      cycle = cycle + 1;
      if (!rst_in) begin
         if (frame_done) begin
            done_count = done_count + 1;
            done_cycle = cycle;
         end
         if (column_full) begin
            full_seen = 1'b1; // back-pressure reached
         end
      end
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Test failed");
      $fatal(1, "stopping on first failure");
   endtask

   task automatic check_pixel(input string name,
                              input logic [raycast_pkg::pixel_bits-1:0] expected,
                              input logic [raycast_pkg::pixel_bits-1:0] actual);
      if (actual !== expected) begin
         abort_run($sformatf("ERROR: %s expected 0x%h actual 0x%h", name, expected, actual));
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         abort_run($sformatf("ERROR: %s expected 0x%h actual 0x%h", name, expected, actual));
      end
   endtask

   // inputs change 2 ns after the rising edge
   task automatic advance_cycle();
      @(posedge pixel_clk_in);
      #2;
   endtask

   // record fields packed msb first in the order hcount, line height, wall side, map value, last
   function automatic logic [raycast_pkg::record_bits-1:0] make_record(
      input logic [8:0] hcount, input logic [7:0] height, input logic wall,
      input logic [3:0] map, input logic last);
      return {hcount, height, wall, map, last};
   endfunction

   // wall spans half the height either side of row 90 and is clipped to the screen
   function automatic logic [15:0] expected_pixel(input logic [7:0] height, input logic wall,
                                                  input logic [3:0] map, input int row);
      int          half;
      int          top;
      int          bottom;
      logic [15:0] base;
      logic [4:0]  red;
      logic [5:0]  green;
      logic [4:0]  blue;
      half   = int'(height) / 2;
      top    = int'(raycast_pkg::half_screen_height) - half;
      bottom = int'(raycast_pkg::half_screen_height) + half;
      if (top < 0) begin
         top = 0;
      end
      if (bottom > int'(raycast_pkg::screen_height)) begin
         bottom = int'(raycast_pkg::screen_height);
      end
      if (row < top || row >= bottom) begin
         return raycast_pkg::background_color; // ceiling or floor
      end
      base = raycast_pkg::wall_palette[map];
      if (!wall) begin
         return base;
      end
      red   = base[15:11] >> 1;  // y side at half brightness
      green = base[10:5] >> 1;
      blue  = base[4:0] >> 1;
      return {red, green, blue};
   endfunction

   task automatic write_column(input logic [raycast_pkg::record_bits-1:0] rec);
      int waited;
      waited = 0;
      while (column_full) begin
         if (waited >= wait_limit) begin
            abort_run("timed out waiting for column_full to drop");
         end else begin
            advance_cycle();
            waited++;
         end
      end
      column_we   = 1'b1;
      column_data = rec;
      advance_cycle();
      column_we   = 1'b0;
   endtask

   task automatic wait_frame_done(input int target);
      int waited;
      waited = 0;
      while (done_count < target) begin
         if (waited >= wait_limit) begin
            abort_run("timed out waiting for frame_done");
         end else begin
            advance_cycle();
            waited++;
         end
      end
   endtask

   // reads back all 180 rows of one column with the data one cycle after the address
   task automatic verify_column(input logic [8:0] hcount, input logic [7:0] height,
                                input logic wall, input logic [3:0] map);
      int addr_int;
      for (int row = 0; row < int'(raycast_pkg::screen_height); row++) begin
         addr_int = row * int'(raycast_pkg::screen_width) + int'(hcount);
         rd_addr  = addr_int[raycast_pkg::fb_addr_bits-1:0];
         advance_cycle();
         check_pixel($sformatf("rd_pixel col %0d row %0d", hcount, row),
                     expected_pixel(height, wall, map, row), rd_pixel);
      end
   endtask

   initial begin
      logic [31:0] rnd;
      int          h;
      pixel_clk_in = 1'b0;
      rst_in       = 1'b1;
      column_we    = 1'b0;
      column_data  = '0;
      rd_addr      = '0;
      repeat (16) @(posedge pixel_clk_in);
      #2;
      rst_in = 1'b0;

      // idle after reset
      for (int i = 0; i < 8; i++) begin
         advance_cycle();
         check_flag("column_full", 1'b0, column_full);
         check_flag("frame_done", 1'b0, frame_done);
      end

      // first frame comes from the table written back to back
      for (int i = 0; i < num_cols; i++) begin
         if (tab_last[i]) begin
            check_flag("frame_done before last column", 1'b0, done_count != 0);
         end
         write_column(make_record(tab_hcount[i], tab_height[i], tab_wall[i], tab_map[i],
                                  tab_last[i]));
         if (i == 0) begin
            first_write_cycle = cycle; // first record accepted on the edge just passed
         end
      end
      check_flag("column_full seen", 1'b1, full_seen);
      wait_frame_done(1);
      // each column holds the flattener for 181 cycles, one column at a time
      if (done_cycle - first_write_cycle < num_cols * 181) begin
         abort_run("frame_done came before the last column was flattened");
      end

      for (int i = 0; i < num_cols; i++) begin
         verify_column(tab_hcount[i], tab_height[i], tab_wall[i], tab_map[i]);
      end
      check_flag("single frame_done pulse", 1'b1, done_count == 1);

      // second frame uses random columns in distinct slots of the right half
      for (int i = 0; i < num_random; i++) begin
         rnd = $random(seed);
         h   = 160 + i * 40 + int'(rnd[4:0]);
         rnd_hcount[i] = h[8:0];
         rnd_height[i] = rnd[15:8];
         rnd_wall[i]   = rnd[16];
         rnd_map[i]    = rnd[23:20];
         write_column(make_record(rnd_hcount[i], rnd_height[i], rnd_wall[i], rnd_map[i],
                                  i == num_random - 1));
      end
      wait_frame_done(2);
      for (int i = 0; i < num_random; i++) begin
         verify_column(rnd_hcount[i], rnd_height[i], rnd_wall[i], rnd_map[i]);
      end
      check_flag("two frame_done pulses", 1'b1, done_count == 2);

      $display("Test passed");
      $finish;
   end

endmodule

/* sources.f */
raycast_pkg.sv
ray_column_fifo.sv
column_flattener.sv
frame_buffer.sv
raycast_backend.sv
raycast_backend_checker.sv
tb_raycast_backend.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, and judge the run from sim.log
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_raycast_backend -f sources.f \
   || { echo "build failed"; exit 1; }

./obj_dir/Vtb_raycast_backend > sim.log 2>&1 || true

grep -q "Test failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Test passed" sim.log || { echo "simulation ended without a result, see sim.log"; exit 1; }
echo "simulation passed"
